// ==== vlog.f ====
source/mandelPkg.sv
source/coordGenerator.sv
source/loadBalancer.sv
source/mandelProcessor.sv
source/pixelArbiter.sv
source/renderTimer.sv
source/mandelRender.sv
sim/mandelRender_asserts.sv
sim/mandelRender_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Mandelbrot render testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mandelRender_tb -Mdir obj_dir -f vlog.f

# The log decides pass or fail
./obj_dir/VmandelRender_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== sim/mandelRender_tb.sv ====
`timescale 1ns/10ps

module mandelRender_tb;
  import mandelPkg::*;

  localparam int    WIDTH       = 16;
  localparam int    HEIGHT      = 12;
  localparam int    PROCS       = 4;
  localparam int    MAX_ITER    = 32;
  localparam int    TICK_CYCLES = 16;
  localparam int    PIXELS      = WIDTH * HEIGHT;
  localparam int    FRAME_LIMIT = 4 * PIXELS * (MAX_ITER + 2);  // Worst case per frame
  localparam int    CYCLE_LIMIT = 3 * FRAME_LIMIT + 2000;       // Three frames plus idle time
  localparam int    BUSY_GAP    = 20;                           // Cycles before the ignored draw
  localparam fixedT ONE         = fixedT'(1) <<< FRAC_BITS;

  logic        CLOCK_50;
  logic        rst;
  logic        draw;
  viewT        view;
  pixelWriteT  pixelWrite;
  logic        pixelWriteEn;
  logic        done;
  logic [15:0] renderTicks;

  colorT       expColor [PIXELS];          // Reference colors by address
  int          writeCount [PIXELS];
  int          lowCycles;                  // Cycles with done low
  int          cycleCount = 0;
  int          errorCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  logic        prevDone;
  logic        prevWriteEn;
  logic [15:0] lfsr;
  pixelWriteT  expWrite;

  mandelRender #(
    .screenWidth(WIDTH), .screenHeight(HEIGHT), .numProcs(PROCS),
    .maxIter(MAX_ITER), .tickCycles(TICK_CYCLES)
  ) mandelRender_i (
    .CLOCK_50(CLOCK_50), .rst(rst), .draw(draw), .view(view),
    .pixelWrite(pixelWrite), .pixelWriteEn(pixelWriteEn),
    .done(done), .renderTicks(renderTicks)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #4 CLOCK_50 = ~CLOCK_50;       // 8 ns period
  end

  // Watchdog
  always @(posedge CLOCK_50) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic colorT mandelRef(fixedT cx, fixedT cy);
    fixedT              x;
    fixedT              y;
    fixedT              xSq;
    fixedT              ySq;
    fixedT              xTimesY;
    logic signed [71:0] prod;
    x = '0;
    y = '0;
    for (int n = 0; n <= MAX_ITER; n++) begin
      prod    = 72'(x) * 72'(x);
      xSq     = fixedT'(prod >>> FRAC_BITS);
      prod    = 72'(y) * 72'(y);
      ySq     = fixedT'(prod >>> FRAC_BITS);
      prod    = 72'(x) * 72'(y);
      xTimesY = fixedT'(prod >>> FRAC_BITS);
      if (longint'(xSq) + longint'(ySq) > (longint'(4) <<< FRAC_BITS)) return colorT'(n);
      if (n == MAX_ITER) return colorT'(n);  // Inside the set
      x = xSq - ySq + cx;
      y = xTimesY + xTimesY + cy;
    end
    return colorT'(MAX_ITER);
  endfunction

  // 16 bit Fibonacci with taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randomBits(input int count, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsrNext(lfsr);               // One step per bit
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic buildExpected(input viewT v);
    fixedT step;
    fixedT cx;
    fixedT cy;
    step = fixedT'(1) <<< (FRAC_BITS - 2 - int'(v.zoom));
    for (int py = 0; py < HEIGHT; py++) begin
      for (int px = 0; px < WIDTH; px++) begin
        cx = v.upperLeftX + fixedT'(px) * step;
        cy = v.upperLeftY - fixedT'(py) * step;  // y shrinks going down
        expColor[py * WIDTH + px] = mandelRef(cx, cy);
      end
    end
  endtask

  task automatic checkPixel(input pixelWriteT got, input pixelWriteT exp);
    if (got !== exp) begin
      errorCount++;
      $display("ERROR pixelWrite: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkTicks(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("ERROR renderTicks: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    testsRun++;
    if (errorCount == startErrors) begin
      $display("Test %0d %s: pass", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: FAIL, %0d errors", testsRun, name, errorCount - startErrors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLOCK_50) begin
    if (!rst) begin
      if (pixelWriteEn) begin
        if (done) begin
          errorCount++;
          $display("A pixel write to address %0d happened while done was high",
                   pixelWrite.addr);
        end
        if (pixelWrite.addr >= PIXELS) begin
          errorCount++;
          $display("Pixel write address %0d is outside the screen", pixelWrite.addr);
        end else begin
          writeCount[pixelWrite.addr]++;
          expWrite.addr  = pixelWrite.addr;
          expWrite.color = expColor[pixelWrite.addr];
          checkPixel(pixelWrite, expWrite);
        end
      end
      if (done && !prevDone && !prevWriteEn) begin
        errorCount++;
        $display("done rose without a pixel write in the cycle before");
      end
      if (!done) lowCycles++;
      prevDone    = done;
      prevWriteEn = pixelWriteEn;
    end
  end

  // One frame from draw to done with an optional ignored draw mid-render
  task automatic runFrame(input viewT v, input logic busyDraw);
    buildExpected(v);
    for (int a = 0; a < PIXELS; a++) writeCount[a] = 0;
    @(posedge CLOCK_50);
    #1;
    draw      = 1'b1;
    view      = v;
    lowCycles = 0;
    @(posedge CLOCK_50);
    #1;
    draw = 1'b0;
    view = '0;
    @(negedge CLOCK_50);
    checkLevel("done", done, 1'b0);
    checkTicks(renderTicks, 16'd0);        // Timer restarted
    if (busyDraw) begin
      repeat (BUSY_GAP) @(posedge CLOCK_50);
      #1;
      draw = 1'b1;
      view = '{upperLeftX: ONE, upperLeftY: -ONE, zoom: 4'd6};
      @(posedge CLOCK_50);
      #1;
      draw = 1'b0;
      view = '0;
      @(negedge CLOCK_50);
      // Timer keeps counting through the ignored draw
      checkTicks(renderTicks, 16'((BUSY_GAP + 1) / TICK_CYCLES));
    end
    while (!done) @(negedge CLOCK_50);
    checkTicks(renderTicks, 16'(lowCycles / TICK_CYCLES));
    repeat (2 * TICK_CYCLES) @(negedge CLOCK_50);
    checkTicks(renderTicks, 16'(lowCycles / TICK_CYCLES));  // Frozen
    checkLevel("done", done, 1'b1);
    for (int a = 0; a < PIXELS; a++) begin
      if (writeCount[a] != 1) begin
        errorCount++;
        $display("Pixel %0d was written %0d times instead of once", a, writeCount[a]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          startErrors;
    viewT        homeView;
    viewT        randView;
    logic [15:0] bitsX;
    logic [15:0] bitsY;
    rst         = 1'b1;
    draw        = 1'b0;
    view        = '0;
    lfsr        = 16'd28;                  // Seed
    lowCycles   = 0;
    prevDone    = 1'b1;
    prevWriteEn = 1'b0;
    for (int a = 0; a < PIXELS; a++) begin
      writeCount[a] = 0;
      expColor[a]   = '0;
    end
    repeat (8) @(posedge CLOCK_50);
    #1 rst = 1'b0;

    // Long enough for a free-running timer to tick
    startErrors = errorCount;
    repeat (2 * TICK_CYCLES) begin
      @(negedge CLOCK_50);
      checkLevel("done", done, 1'b1);
      checkLevel("pixelWriteEn", pixelWriteEn, 1'b0);
      checkTicks(renderTicks, 16'd0);
    end
    reportTest("reset state", startErrors);

    homeView.upperLeftX = -(ONE <<< 1);    // -2.0
    homeView.upperLeftY = ONE + (ONE >>> 1);  // 1.5
    homeView.zoom       = 4'd0;
    startErrors = errorCount;
    runFrame(homeView, 1'b0);
    reportTest("full frame, done and timer", startErrors);

    startErrors = errorCount;
    runFrame(homeView, 1'b1);
    reportTest("draw while busy is ignored", startErrors);

    // Steps of 1/8 around the left half of the set
    randomBits(4, bitsX);
    randomBits(3, bitsY);
    randView.upperLeftX = -(ONE <<< 1) + (fixedT'(bitsX) <<< (FRAC_BITS - 3));
    randView.upperLeftY = (ONE >>> 1) + (fixedT'(bitsY) <<< (FRAC_BITS - 3));
    randView.zoom       = 4'd2;
    startErrors = errorCount;
    runFrame(randView, 1'b0);
    reportTest("random view at zoom 2", startErrors);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             testsRun, testsRun - testsFailed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== sim/mandelRender_asserts.sv ====
`timescale 1ns/10ps

module mandelRender_asserts #(
  parameter int numProcs  = mandelPkg::DEFAULT_PROCS,
  parameter int numPixels = mandelPkg::DEFAULT_WIDTH * mandelPkg::DEFAULT_HEIGHT
) (
  input logic                  CLOCK_50,
  input logic                  rst,
  input logic [numProcs-1:0]   resultValid,
  input logic [numProcs-1:0]   store,
  input mandelPkg::pixelWriteT pixelWrite,
  input logic                  pixelWriteEn
);

  // At most one grant per cycle
  storeOneHot: assert property (@(posedge CLOCK_50) disable iff (rst) $onehot0(store))
    else $error("store is not one-hot or zero: %b", store);

  grantOnlyValid: assert property (@(posedge CLOCK_50) disable iff (rst)
    (store & ~resultValid) == '0)
    else $error("store granted to a processor without resultValid");

  strobeMatchesStore: assert property (@(posedge CLOCK_50) disable iff (rst)
    pixelWriteEn == |store)
    else $error("pixelWriteEn does not match the store vector");

  addrInRange: assert property (@(posedge CLOCK_50) disable iff (rst)
    pixelWriteEn |-> pixelWrite.addr < numPixels)
    else $error("pixelWrite addr 0x%h beyond the screen", pixelWrite.addr);

endmodule

// Screen of the testbench, 16 by 12
bind pixelArbiter mandelRender_asserts #(.numProcs(numProcs), .numPixels(16 * 12)) arbAsserts_i (
  .CLOCK_50(CLOCK_50), .rst(rst), .resultValid(resultValid), .store(store),
  .pixelWrite(pixelWrite), .pixelWriteEn(pixelWriteEn)
);

// ==== source/mandelRender.sv ====
`timescale 1ns/10ps

module mandelRender #(
  parameter int screenWidth  = mandelPkg::DEFAULT_WIDTH,
  parameter int screenHeight = mandelPkg::DEFAULT_HEIGHT,
  parameter int numProcs     = mandelPkg::DEFAULT_PROCS,
  parameter int maxIter      = mandelPkg::DEFAULT_MAX_ITER,
  parameter int tickCycles   = mandelPkg::DEFAULT_TICK_CYCLES
) (
  input  logic                  CLOCK_50,
  input  logic                  rst,
  input  logic                  draw,
  input  mandelPkg::viewT       view,
  output mandelPkg::pixelWriteT pixelWrite,
  output logic                  pixelWriteEn,
  output logic                  done,
  output logic [15:0]           renderTicks
);
  import mandelPkg::*;

  logic                acceptedDraw;
  logic                jobValid;
  logic                jobReady;
  logic                allIssued;
  pixelJobT            job;                // Shared job bus
  logic [numProcs-1:0] dispatch;
  logic [numProcs-1:0] procIdle;
  logic [numProcs-1:0] resultValid;
  logic [numProcs-1:0] store;
  pixelWriteT          rawResults [numProcs];  // Row and column form
  pixelWriteT          results [numProcs];     // Linear address form

  assign acceptedDraw = draw && done;      // Ignored while rendering

  ////////////////////////////////////////////////////////////////////////////
  // Done flag
  ////////////////////////////////////////////////////////////////////////////

  // Rises right after the last write, when every processor is idle or granted
  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      done <= 1'b1;
    end else if (acceptedDraw) begin
      done <= 1'b0;
    end else if (allIssued && &(procIdle | store)) begin
      done <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////////////////////

  coordGenerator #(.screenWidth(screenWidth), .screenHeight(screenHeight)) coordGen_i (
    .CLOCK_50(CLOCK_50), .rst(rst), .draw(acceptedDraw), .view(view),
    .jobReady(jobReady), .jobValid(jobValid), .job(job), .allIssued(allIssued)
  );

  loadBalancer #(.numProcs(numProcs)) balancer_i (
    .jobValid(jobValid), .jobReady(jobReady), .procIdle(procIdle), .dispatch(dispatch)
  );

  for (genvar i = 0; i < numProcs; i++) begin : procGen
    mandelProcessor #(.maxIter(maxIter)) proc_i (
      .CLOCK_50(CLOCK_50), .rst(rst), .dispatch(dispatch[i]), .job(job),
      .idle(procIdle[i]), .resultValid(resultValid[i]), .result(rawResults[i]),
      .store(store[i])
    );
    // py * width + px for the frame buffer
    assign results[i].addr  = 19'(rawResults[i].addr[18:10]) * 19'(screenWidth)
                              + 19'(rawResults[i].addr[9:0]);
    assign results[i].color = rawResults[i].color;
  end

  pixelArbiter #(.numProcs(numProcs)) arbiter_i (
    .CLOCK_50(CLOCK_50), .rst(rst), .resultValid(resultValid), .results(results),
    .store(store), .pixelWrite(pixelWrite), .pixelWriteEn(pixelWriteEn)
  );

  renderTimer #(.tickCycles(tickCycles)) timer_i (
    .CLOCK_50(CLOCK_50), .rst(rst), .start(acceptedDraw), .running(!done),
    .renderTicks(renderTicks)
  );

endmodule

// ==== source/renderTimer.sv ====
`timescale 1ns/10ps

module renderTimer #(
  parameter int tickCycles = mandelPkg::DEFAULT_TICK_CYCLES
) (
  input  logic        CLOCK_50,
  input  logic        rst,
  input  logic        start,
  input  logic        running,
  output logic [15:0] renderTicks
);

  localparam int               PRE_W    = (tickCycles > 1) ? $clog2(tickCycles) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(tickCycles - 1);

  logic [PRE_W-1:0] prescale;             // Cycles into the current tick

  always_ff @(posedge CLOCK_50) begin
    if (rst || start) begin
      prescale    <= '0;
      renderTicks <= '0;
    end else if (running) begin
      if (prescale == PRE_LAST) begin
        prescale    <= '0;
        renderTicks <= renderTicks + 16'd1;
      end else begin
        prescale <= prescale + 1'b1;
      end
    end
    // Frozen while not running
  end

endmodule

// ==== source/pixelArbiter.sv ====
`timescale 1ns/10ps

module pixelArbiter #(
  parameter int numProcs = mandelPkg::DEFAULT_PROCS
) (
  input  logic                  CLOCK_50,
  input  logic                  rst,
  input  logic [numProcs-1:0]   resultValid,
  input  mandelPkg::pixelWriteT results [numProcs],
  output logic [numProcs-1:0]   store,
  output mandelPkg::pixelWriteT pixelWrite,
  output logic                  pixelWriteEn
);

  localparam int IDX_W = (numProcs > 1) ? $clog2(numProcs) : 1;

  logic [IDX_W-1:0] lastGrant;            // Most recent winner
  logic [IDX_W-1:0] grantIdx;
  logic             found;

  // Search starts just past the last winner
  always_comb begin : pickNext
    int cand;
    store    = '0;
    grantIdx = lastGrant;
    found    = 1'b0;
    for (int k = 1; k <= numProcs; k++) begin
      cand = (int'(lastGrant) + k) % numProcs;
      if (!found && resultValid[cand]) begin
        found       = 1'b1;
        grantIdx    = IDX_W'(cand);
        store[cand] = 1'b1;
      end
    end
  end

  // Rotate priority on each grant
  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      lastGrant <= IDX_W'(numProcs - 1);  // Processor 0 first
    end else if (found) begin
      lastGrant <= grantIdx;
    end
  end

  // Frame buffer write in the grant cycle
  assign pixelWrite   = results[grantIdx];
  assign pixelWriteEn = found;

endmodule

// ==== source/mandelProcessor.sv ====
`timescale 1ns/10ps

module mandelProcessor #(
  parameter int maxIter = mandelPkg::DEFAULT_MAX_ITER
) (
  input  logic                  CLOCK_50,
  input  logic                  rst,
  input  logic                  dispatch,
  input  mandelPkg::pixelJobT   job,
  output logic                  idle,
  output logic                  resultValid,
  output mandelPkg::pixelWriteT result,   // Address as {py, px}
  input  logic                  store
);
  import mandelPkg::*;

  typedef enum logic [1:0] {IDLE, ITERATE, HOLD} stateT;

  // 4.0 in a 37 bit sum
  localparam logic signed [36:0] ESCAPE = 37'sd4 <<< FRAC_BITS;

  stateT       state;
  fixedT       x;
  fixedT       y;
  fixedT       cx;
  fixedT       cy;
  iterT        n;                         // Steps taken so far
  logic [18:0] addr;                      // Row and column of the pixel

  logic signed [71:0] xxFull;
  logic signed [71:0] yyFull;
  logic signed [71:0] xyFull;
  fixedT              x2;
  fixedT              y2;
  fixedT              xy;
  logic signed [36:0] magSq;              // One extra bit for the sum
  logic               escaped;
  logic               atLimit;

  ////////////////////////////////////////////////////////////////////////////
  // One z = z^2 + c step per cycle
  ////////////////////////////////////////////////////////////////////////////

  assign xxFull = x * x;                  // Full width products
  assign yyFull = y * y;
  assign xyFull = x * y;

  assign x2 = fixedT'(xxFull >>> FRAC_BITS);
  assign y2 = fixedT'(yyFull >>> FRAC_BITS);
  assign xy = fixedT'(xyFull >>> FRAC_BITS);

  assign magSq   = 37'(x2) + 37'(y2);
  assign escaped = magSq > ESCAPE;
  assign atLimit = n == iterT'(maxIter);

  // Control FSM
  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (dispatch) state <= ITERATE;
        ITERATE: if (escaped || atLimit) state <= HOLD;
        HOLD:    if (store) state <= IDLE;  // Free the cycle after grant
        default: state <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLOCK_50) begin
    if (state == IDLE && dispatch) begin
      x    <= '0;
      y    <= '0;
      cx   <= job.cx;
      cy   <= job.cy;
      n    <= '0;
      addr <= {job.py, job.px};
    end else if (state == ITERATE && !escaped && !atLimit) begin
      x <= x2 - y2 + cx;
      y <= (xy <<< 1) + cy;               // 2xy + cy
      n <= n + 16'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status and result
  ////////////////////////////////////////////////////////////////////////////

  assign idle         = state == IDLE;
  assign resultValid  = state == HOLD;     // Count frozen while held
  assign result.addr  = addr;
  assign result.color = n[2:0];            // Also right at the limit

endmodule

// ==== source/loadBalancer.sv ====
`timescale 1ns/10ps

module loadBalancer #(
  parameter int numProcs = mandelPkg::DEFAULT_PROCS
) (
  input  logic                jobValid,
  output logic                jobReady,
  input  logic [numProcs-1:0] procIdle,
  output logic [numProcs-1:0] dispatch
);

  logic [numProcs-1:0] pick;              // Lowest idle processor, one-hot
  logic                found;

  // Any idle processor can take the job
  assign jobReady = |procIdle;

  // Priority search from processor 0 upward
  always_comb begin
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < numProcs; i++) begin
      if (procIdle[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
  end

  // Dispatch lands in the transfer cycle
  assign dispatch = jobValid ? pick : '0;

endmodule

// ==== source/coordGenerator.sv ====
`timescale 1ns/10ps

module coordGenerator #(
  parameter int screenWidth  = mandelPkg::DEFAULT_WIDTH,
  parameter int screenHeight = mandelPkg::DEFAULT_HEIGHT
) (
  input  logic                CLOCK_50,
  input  logic                rst,
  input  logic                draw,       // Already qualified by done
  input  mandelPkg::viewT     view,
  input  logic                jobReady,
  output logic                jobValid,
  output mandelPkg::pixelJobT job,
  output logic                allIssued
);
  import mandelPkg::*;

  localparam logic [9:0] LAST_X = 10'(screenWidth - 1);
  localparam logic [8:0] LAST_Y = 9'(screenHeight - 1);

  fixedT leftX;                           // Row start for cx
  fixedT step;                            // Pixel pitch
  logic  start;
  logic  xfer;
  logic  lastPixel;

  assign start     = draw && allIssued;
  assign xfer      = jobValid && jobReady;
  assign lastPixel = (job.px == LAST_X) && (job.py == LAST_Y);

  // Frame control
  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      jobValid  <= 1'b0;
      allIssued <= 1'b1;
    end else if (start) begin
      jobValid  <= 1'b1;                  // First job next cycle
      allIssued <= 1'b0;
    end else if (xfer && lastPixel) begin
      jobValid  <= 1'b0;
      allIssued <= 1'b1;                  // Whole screen handed out
    end
  end

  // Raster walk, exact by repeated addition
  always_ff @(posedge CLOCK_50) begin
    if (start) begin
      leftX  <= view.upperLeftX;
      step   <= fixedT'(1) << (FRAC_BITS - 2 - int'(view.zoom));
      job.cx <= view.upperLeftX;
      job.cy <= view.upperLeftY;
      job.px <= '0;
      job.py <= '0;
    end else if (xfer && !lastPixel) begin
      if (job.px == LAST_X) begin
        // Wrap to next row
        job.px <= '0;
        job.py <= job.py + 9'd1;
        job.cx <= leftX;
        job.cy <= job.cy - step;          // Rows go down in y
      end else begin
        job.px <= job.px + 10'd1;
        job.cx <= job.cx + step;
      end
    end
  end

endmodule

// ==== source/mandelPkg.sv ====
package mandelPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed point and iteration types
  ////////////////////////////////////////////////////////////////////////////

  localparam int FRAC_BITS = 32;            // Binary point position

  // 4 integer bits incl sign, 32 fraction bits
  typedef logic signed [35:0] fixedT;

  typedef logic [2:0]  colorT;              // Frame buffer pixel color
  typedef logic [15:0] iterT;               // Escape count

  ////////////////////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////////////////////

  // One pixel to iterate
  typedef struct packed {
    fixedT      cx;                         // Real part of c
    fixedT      cy;                         // Imaginary part of c
    logic [9:0] px;                         // Screen column
    logic [8:0] py;                         // Screen row
  } pixelJobT;

  // Frame buffer write
  typedef struct packed {
    logic [18:0] addr;                      // Linear pixel address
    colorT       color;
  } pixelWriteT;

  // View latched at draw
  typedef struct packed {
    fixedT      upperLeftX;
    fixedT      upperLeftY;
    logic [3:0] zoom;                       // Step is 2^-(zoom+2)
  } viewT;

  ////////////////////////////////////////////////////////////////////////////
  // Top level defaults
  ////////////////////////////////////////////////////////////////////////////

  localparam int DEFAULT_WIDTH       = 640;
  localparam int DEFAULT_HEIGHT      = 480;
  localparam int DEFAULT_PROCS       = 4;
  localparam int DEFAULT_MAX_ITER    = 1000;
  localparam int DEFAULT_TICK_CYCLES = 50000;  // 1 ms at 50 MHz

endpackage
